/* dv/cpu_ctrl_assertions.sv */
// Control unit output checks
`timescale 1ns/1ns
`default_nettype none

module cpu_ctrl_assertions (
    input logic                  clk,
    input logic                  rst,
    input logic                  ni,
    input ctrl_pkg::reg_upd_t    upd,
    input ctrl_pkg::stack_ctrl_t stk
);

    // a stack byte is either written or read, never both
    wrq_pul_excl: assert property (@(posedge clk) disable iff (rst) !(stk.wrq && stk.pul_en))
        else $error("wrq and pul_en high in the same cycle");

    sel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(stk.psh_sel))
        else $error("psh_sel selects more than one register");

    upd_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(upd))
        else $error("more than one register update strobe");

    // state is known from the second reset edge on
    quiet_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (!ni && !stk.wrq && upd == '0))
        else $error("ni, wrq or upd active during reset");

endmodule

`default_nettype wire

/* dv/cpu_ctrl_tb.sv */
// CPU control unit testbench
`timescale 1ns/1ns
`default_nettype none

module cpu_ctrl_tb;

    localparam int sample_delay = 10;
    localparam int max_cycles   = 400;

    // one strobe per register with up_a in the top bit
    localparam ctrl_pkg::reg_upd_t upd_none = 7'b0000000;
    localparam ctrl_pkg::reg_upd_t upd_a    = 7'b1000000;
    localparam ctrl_pkg::reg_upd_t upd_b    = 7'b0100000;
    localparam ctrl_pkg::reg_upd_t upd_d    = 7'b0010000;
    localparam ctrl_pkg::reg_upd_t upd_x    = 7'b0001000;
    localparam ctrl_pkg::reg_upd_t upd_y    = 7'b0000100;
    localparam ctrl_pkg::reg_upd_t upd_u    = 7'b0000010;
    localparam ctrl_pkg::reg_upd_t upd_s    = 7'b0000001;

    typedef struct packed {
        logic [7:0]         op;
        logic [7:0]         postdata;
        logic [15:0]        data;
        isa_pkg::cc_t       cc;
        logic [15:0]        exp_pc;
        ctrl_pkg::reg_upd_t exp_upd;
        int                 exp_bytes;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  cen;
    logic                  mem_busy;
    logic [7:0]            op;
    logic [7:0]            postdata;
    logic [15:0]           data;
    isa_pkg::cc_t          cc;
    logic [15:0]           pc;
    logic                  ni;
    logic                  mem16;
    ctrl_pkg::reg_upd_t    upd;
    ctrl_pkg::stack_ctrl_t stk;

    row_t                  rows[$];
    ctrl_pkg::stack_ctrl_t exp_stk[$];
    logic [31:0]           lfsr = 32'h7220_d8ec;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    cpu_ctrl i_cpu_ctrl (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .mem_busy (mem_busy),
        .op       (op),
        .postdata (postdata),
        .data     (data),
        .cc       (cc),
        .pc       (pc),
        .ni       (ni),
        .mem16    (mem16),
        .upd      (upd),
        .stk      (stk)
    );

    bind cpu_ctrl cpu_ctrl_assertions u_assertions (
        .clk (clk),
        .rst (rst),
        .ni  (ni),
        .upd (upd),
        .stk (stk)
    );

    // galois lfsr over x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) lfsr = lfsr ^ 32'h8020_0003;
        return out;
    endfunction

    // operand bytes that follow the opcode
    function automatic int operand_bytes(input logic [7:0] code);
        if (code inside {isa_pkg::op_ldd, isa_pkg::op_ldx, isa_pkg::op_ldy, isa_pkg::op_ldu,
                         isa_pkg::op_lds, isa_pkg::op_jmp} || code[7:4] == isa_pkg::grp_lbr) begin
            return 2;
        end
        if (code inside {isa_pkg::op_lda, isa_pkg::op_ldb, isa_pkg::op_pshs, isa_pkg::op_puls} ||
            code[7:4] == isa_pkg::grp_sbr) begin
            return 1;
        end
        return 0;
    endfunction

    task automatic fail_now();
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic stop_run(input string why);
        $display("%0t ns: %s", $time, why);
        fail_now();
    endtask

    task automatic check_pc(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_upd(input string name, input ctrl_pkg::reg_upd_t got,
                             input ctrl_pkg::reg_upd_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_stk(input string name, input ctrl_pkg::stack_ctrl_t got,
                             input ctrl_pkg::stack_ctrl_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %0t ns %s got %0d expected %0d", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic add_row(input logic [7:0] code, input logic [7:0] pb, input logic [15:0] d,
                           input logic [7:0] flags, input logic [15:0] exp_pc,
                           input ctrl_pkg::reg_upd_t exp_upd, input int exp_bytes);
        rows.push_back('{code, pb, d, flags, exp_pc, exp_upd, exp_bytes});
    endtask

    // expected pc chains from 0 after reset
    task automatic load_table();
        add_row(isa_pkg::op_nop, 8'h00, 16'h0000, 8'h00, 16'h0001, upd_none, 0);
        add_row(isa_pkg::op_lda, 8'h00, 16'h00a5, 8'h00, 16'h0003, upd_a, 0);
        add_row(isa_pkg::op_ldb, 8'h00, 16'h005a, 8'h00, 16'h0005, upd_b, 0);
        add_row(isa_pkg::op_ldd, 8'h00, 16'h1234, 8'h00, 16'h0008, upd_d, 0);
        add_row(isa_pkg::op_ldx, 8'h00, 16'h2345, 8'h00, 16'h000b, upd_x, 0);
        add_row(isa_pkg::op_ldy, 8'h00, 16'h3456, 8'h00, 16'h000e, upd_y, 0);
        add_row(isa_pkg::op_ldu, 8'h00, 16'h4567, 8'h00, 16'h0011, upd_u, 0);
        add_row(isa_pkg::op_lds, 8'h00, 16'h5678, 8'h00, 16'h0014, upd_s, 0);
        // short branches with flags n z v c in bits 3 to 0
        add_row({isa_pkg::grp_sbr, isa_pkg::cond_always}, 8'h00, 16'h0010, 8'h00, 16'h0026,
                upd_none, 0);
        add_row({isa_pkg::grp_sbr, isa_pkg::cond_never}, 8'h00, 16'h0010, 8'h00, 16'h0028,
                upd_none, 0);
        add_row({isa_pkg::grp_sbr, isa_pkg::cond_hi}, 8'h00, 16'h00f0, 8'h00, 16'h001a,
                upd_none, 0);
        add_row({isa_pkg::grp_sbr, isa_pkg::cond_ls}, 8'h00, 16'h0005, 8'h00, 16'h001c,
                upd_none, 0);
        add_row({isa_pkg::grp_sbr, isa_pkg::cond_cc}, 8'h00, 16'h0005, 8'h01, 16'h001e,
                upd_none, 0);
        add_row({isa_pkg::grp_sbr, isa_pkg::cond_cs}, 8'h00, 16'h0004, 8'h01, 16'h0024,
                upd_none, 0);
        add_row({isa_pkg::grp_sbr, isa_pkg::cond_ne}, 8'h00, 16'h0004, 8'h04, 16'h0026,
                upd_none, 0);
        add_row({isa_pkg::grp_sbr, isa_pkg::cond_eq}, 8'h00, 16'h00fe, 8'h04, 16'h0026,
                upd_none, 0);
        add_row({isa_pkg::grp_sbr, isa_pkg::cond_vc}, 8'h00, 16'h0020, 8'h02, 16'h0028,
                upd_none, 0);
        add_row({isa_pkg::grp_sbr, isa_pkg::cond_vs}, 8'h00, 16'h0020, 8'h02, 16'h004a,
                upd_none, 0);
        add_row({isa_pkg::grp_sbr, isa_pkg::cond_pl}, 8'h00, 16'h00c0, 8'h08, 16'h004c,
                upd_none, 0);
        add_row({isa_pkg::grp_sbr, isa_pkg::cond_mi}, 8'h00, 16'h00c0, 8'h08, 16'h000e,
                upd_none, 0);
        add_row({isa_pkg::grp_sbr, isa_pkg::cond_ge}, 8'h00, 16'h0010, 8'h0a, 16'h0020,
                upd_none, 0);
        add_row({isa_pkg::grp_sbr, isa_pkg::cond_lt}, 8'h00, 16'h0002, 8'h08, 16'h0024,
                upd_none, 0);
        add_row({isa_pkg::grp_sbr, isa_pkg::cond_gt}, 8'h00, 16'h0002, 8'h0c, 16'h0026,
                upd_none, 0);
        add_row({isa_pkg::grp_sbr, isa_pkg::cond_le}, 8'h00, 16'h0008, 8'h04, 16'h0030,
                upd_none, 0);
        // upper flags must not matter
        add_row({isa_pkg::grp_sbr, isa_pkg::cond_gt}, 8'h00, 16'h0003, 8'hf0, 16'h0035,
                upd_none, 0);
        add_row({isa_pkg::grp_lbr, isa_pkg::cond_always}, 8'h00, 16'h0100, 8'h00, 16'h0138,
                upd_none, 0);
        add_row({isa_pkg::grp_lbr, isa_pkg::cond_eq}, 8'h00, 16'h1234, 8'h00, 16'h013b,
                upd_none, 0);
        add_row({isa_pkg::grp_lbr, isa_pkg::cond_lt}, 8'h00, 16'hff00, 8'h02, 16'h003e,
                upd_none, 0);
        add_row(isa_pkg::op_jmp, 8'h00, 16'h4000, 8'h00, 16'h4000, upd_none, 0);
        add_row(isa_pkg::op_pshs, 8'hff, 16'h0000, 8'h00, 16'h4002, upd_none, 12);
        add_row(isa_pkg::op_puls, 8'hff, 16'h0000, 8'h00, 16'h4004, upd_none, 12);
        add_row(isa_pkg::op_pshs, 8'h52, 16'h0000, 8'h00, 16'h4006, upd_none, 5);
        add_row(isa_pkg::op_puls, 8'h00, 16'h0000, 8'h00, 16'h4008, upd_none, 0);
        add_row(isa_pkg::op_puls, 8'h81, 16'h0000, 8'h00, 16'h400a, upd_none, 3);
        add_row(isa_pkg::op_nop, 8'h00, 16'h0000, 8'h00, 16'h400b, upd_none, 0);
    endtask

    task automatic add_stack_byte(input int b, input logic hi, input logic push, input int n);
        ctrl_pkg::stack_ctrl_t e;
        e.psh_sel = 8'd1 << b;
        e.hi_lon  = hi;
        e.wrq     = push;
        e.pul_en  = ~push;
        e.busy    = exp_stk.size() < n - 1;
        exp_stk.push_back(e);
    endtask

    // push walks bit 7 down with low byte first, pull walks bit 0 up with high byte first
    task automatic fill_stack_model(input logic [7:0] code, input logic [7:0] pb);
        int n;
        n = 0;
        exp_stk.delete();
        for (int b = 0; b < 8; b++) begin
            if (pb[b]) n += (b >= isa_pkg::pb_x) ? 2 : 1;
        end
        if (code == isa_pkg::op_pshs) begin
            for (int b = 7; b >= 0; b--) begin
                if (pb[b]) begin
                    add_stack_byte(b, 1'b0, 1'b1, n);
                    if (b >= isa_pkg::pb_x) add_stack_byte(b, 1'b1, 1'b1, n);
                end
            end
        end else if (code == isa_pkg::op_puls) begin
            for (int b = 0; b < 8; b++) begin
                if (pb[b]) begin
                    if (b >= isa_pkg::pb_x) add_stack_byte(b, 1'b1, 1'b0, n);
                    add_stack_byte(b, 1'b0, 1'b0, n);
                end
            end
        end
    endtask

    task automatic run_row(input row_t r);
        logic                  stress;
        logic                  active;
        logic                  was_active;
        logic                  done;
        int                    cycles;
        int                    bytes;
        int                    nb;
        int                    idx;
        int                    last_idx;
        logic [15:0]           prev_pc;
        logic                  prev_ni;
        ctrl_pkg::reg_upd_t    prev_upd;
        ctrl_pkg::stack_ctrl_t prev_stk;
        ctrl_pkg::stack_ctrl_t want;
        fill_stack_model(r.op, r.postdata);
        stress     = lfsr_bit();
        was_active = 1'b1;
        done       = 1'b0;
        cycles     = 0;
        bytes      = 0;
        nb         = operand_bytes(r.op);
        last_idx   = nb + ((r.exp_bytes == 0) ? 1 : r.exp_bytes);
        idx        = 0;
        while (!done) begin
            @(negedge clk);
            op       = r.op;
            postdata = r.postdata;
            data     = r.data;
            cc       = r.cc;
            if (stress) begin
                cen      = lfsr_bit() | lfsr_bit();
                mem_busy = lfsr_bit() & lfsr_bit();
            end else begin
                cen      = 1'b1;
                mem_busy = 1'b0;
            end
            #sample_delay;
            active = cen & ~mem_busy;
            // a held cycle must leave every output as it was
            if (!was_active) begin
                check_pc("pc", pc, prev_pc);
                check_flag("ni", ni, prev_ni);
                check_upd("upd", upd, prev_upd);
                check_stk("stk", stk, prev_stk);
            end
            if (active && (stk.wrq || stk.pul_en)) begin
                if (exp_stk.size() == 0) stop_run("more stack bytes than the postbyte selects");
                want = exp_stk.pop_front();
                check_stk("stk", stk, want);
                bytes++;
            end
            // fetch is cycle 0, operand bytes follow, execute starts at nb + 1
            check_flag("ni", ni, idx == last_idx);
            check_flag("mem16", mem16, nb == 2 && idx >= 1 && idx <= nb);
            check_upd("upd", upd, (idx == nb + 1) ? r.exp_upd : upd_none);
            if (active) idx++;
            done       = active & ni;
            was_active = active;
            prev_pc    = pc;
            prev_ni    = ni;
            prev_upd   = upd;
            prev_stk   = stk;
            cycles++;
            if (!done && cycles >= max_cycles) stop_run("timeout waiting for end of instruction");
        end
        check_count("stack bytes", bytes, r.exp_bytes);
        @(posedge clk);
        #sample_delay;
        check_pc("pc", pc, r.exp_pc);
    endtask

    initial begin
        int wait_cycles;
        cen      = 1'b0;
        mem_busy = 1'b0;
        op       = isa_pkg::op_nop;
        postdata = 8'h00;
        data     = 16'h0000;
        cc       = '0;
        load_table();
        wait_cycles = 0;
        do begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > 100) stop_run("reset was never released");
        end while (rst);
        #sample_delay;
        check_pc("pc", pc, 16'h0000);
        check_flag("ni", ni, 1'b0);
        check_flag("mem16", mem16, 1'b0);
        check_upd("upd", upd, upd_none);
        check_stk("stk", stk, '0);
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    localparam int half_period  = 20;
    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // released on a falling edge, away from the capture edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* filelist.f */
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/branch_cond.sv
hw/stack_seq.sv
hw/ucode_seq.sv
hw/cpu_ctrl.sv
dv/tb_clk_gen.sv
dv/cpu_ctrl_assertions.sv
dv/cpu_ctrl_tb.sv

/* hw/branch_cond.sv */
// Branch condition evaluator
`timescale 1ns/1ns
`default_nettype none

module branch_cond (
    input  logic          [7:0] op,
    input  isa_pkg::cc_t        cc,
    output logic                branch
);

    logic cond_ok;
    logic is_branch;

    assign is_branch = op[7:4] == isa_pkg::grp_sbr || op[7:4] == isa_pkg::grp_lbr;

    always_comb begin
        case (isa_pkg::cond_t'(op[3:0]))
            isa_pkg::cond_always: cond_ok = 1'b1;
            isa_pkg::cond_never:  cond_ok = 1'b0;
            isa_pkg::cond_hi:     cond_ok = ~(cc.c | cc.z);
            isa_pkg::cond_ls:     cond_ok = cc.c | cc.z;
            isa_pkg::cond_cc:     cond_ok = ~cc.c;
            isa_pkg::cond_cs:     cond_ok = cc.c;
            isa_pkg::cond_ne:     cond_ok = ~cc.z;
            isa_pkg::cond_eq:     cond_ok = cc.z;
            isa_pkg::cond_vc:     cond_ok = ~cc.v;
            isa_pkg::cond_vs:     cond_ok = cc.v;
            isa_pkg::cond_pl:     cond_ok = ~cc.n;
            isa_pkg::cond_mi:     cond_ok = cc.n;
            // signed compares
            isa_pkg::cond_ge:     cond_ok = cc.n == cc.v;
            isa_pkg::cond_lt:     cond_ok = cc.n != cc.v;
            isa_pkg::cond_gt:     cond_ok = ~cc.z & (cc.n == cc.v);
            isa_pkg::cond_le:     cond_ok = cc.z | (cc.n != cc.v);
            default:              cond_ok = 1'b0;
        endcase
    end

    assign branch = is_branch & cond_ok;

endmodule

`default_nettype wire

/* hw/cpu_ctrl.sv */
// CPU control unit top
`timescale 1ns/1ns
`default_nettype none

module cpu_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  logic                  mem_busy,
    input  logic            [7:0] op,
    input  logic            [7:0] postdata,
    input  logic           [15:0] data,
    input  isa_pkg::cc_t          cc,
    output logic           [15:0] pc,
    output logic                  ni,
    output logic                  mem16,
    output ctrl_pkg::reg_upd_t    upd,
    output ctrl_pkg::stack_ctrl_t stk
);

    ctrl_pkg::uc_word_t uc;
    logic               branch;
    logic               short_branch;
    logic               long_branch;

    ucode_seq u_ucode (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .mem_busy (mem_busy),
        .op       (op),
        .branch   (branch),
        .stk_busy (stk.busy),
        .uc       (uc)
    );

    branch_cond u_branch (
        .op     (op),
        .cc     (cc),
        .branch (branch)
    );

    stack_seq u_stack (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .mem_busy (mem_busy),
        .postdata (postdata),
        .uc       (uc),
        .stk      (stk)
    );

    assign ni    = uc.ni;
    assign mem16 = uc.mem16;

    assign short_branch = uc.set_pc_branch8 & branch;
    assign long_branch  = uc.set_pc_branch16 & branch;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= 16'd0;
        end else if (cen && !mem_busy) begin
            pc <= uc.pc_step     ? pc + 16'd1 :
                  short_branch   ? pc + {{8{data[7]}}, data[7:0]} :
                  long_branch    ? pc + data :
                  uc.set_pc_jmp  ? data : pc;
        end
    end

    // a/b by bit 0, 16-bit target by bits 3:1
    always_comb begin
        upd.up_a = uc.up_ld8 & ~op[0];
        upd.up_b = uc.up_ld8 & op[0];
        upd.up_d = uc.up_ld16 && op[3:1] == 3'd0;
        upd.up_x = uc.up_ld16 && op[3:1] == 3'd1;
        upd.up_y = uc.up_ld16 && op[3:1] == 3'd2;
        upd.up_u = uc.up_ld16 && op[3:1] == 3'd3;
        upd.up_s = uc.up_ld16 && op[3:1] == 3'd4;
    end

endmodule

`default_nettype wire

/* hw/ctrl_pkg.sv */
// Control unit signal bundles
`default_nettype none

package ctrl_pkg;

    // microcode control word
    typedef struct packed {
        logic pc_step;
        logic set_pc_branch8;
        logic set_pc_branch16;
        logic set_pc_jmp;
        logic up_ld8;
        logic up_ld16;
        logic psh_go;
        logic pul_go;
        // operand is two bytes wide
        logic mem16;
        logic opd;
        logic ni;
    } uc_word_t;

    // stack bus cycle control
    typedef struct packed {
        // one-hot, same bit order as the postbyte
        logic [7:0] psh_sel;
        logic       hi_lon;
        logic       wrq;
        logic       pul_en;
        // more bytes follow the current one
        logic       busy;
    } stack_ctrl_t;

    // register write strobes
    typedef struct packed {
        logic up_a;
        logic up_b;
        logic up_d;
        logic up_x;
        logic up_y;
        logic up_u;
        logic up_s;
    } reg_upd_t;

endpackage

`default_nettype wire

/* hw/isa_pkg.sv */
// CPU instruction set definitions
`default_nettype none

package isa_pkg;

    // condition codes, e in bit 7 down to c in bit 0
    typedef struct packed {
        logic e;
        logic f;
        logic h;
        logic i;
        logic n;
        logic z;
        logic v;
        logic c;
    } cc_t;

    // supported opcodes
    localparam logic [7:0] op_nop  = 8'h12;
    // lda and ldb differ only in bit 0
    localparam logic [7:0] op_lda  = 8'h86;
    localparam logic [7:0] op_ldb  = 8'h87;
    // 16-bit loads carry the register index in bits 3:1
    localparam logic [7:0] op_ldd  = 8'hc0;
    localparam logic [7:0] op_ldx  = 8'hc2;
    localparam logic [7:0] op_ldy  = 8'hc4;
    localparam logic [7:0] op_ldu  = 8'hc6;
    localparam logic [7:0] op_lds  = 8'hc8;
    localparam logic [7:0] op_jmp  = 8'h7e;
    localparam logic [7:0] op_pshs = 8'h14;
    localparam logic [7:0] op_puls = 8'h15;

    // branch groups by upper nibble, condition in the lower one
    localparam logic [3:0] grp_sbr = 4'h2;
    localparam logic [3:0] grp_lbr = 4'h3;

    typedef enum logic [3:0] {
        cond_always, cond_never, cond_hi, cond_ls,
        cond_cc,     cond_cs,    cond_ne, cond_eq,
        cond_vc,     cond_vs,    cond_pl, cond_mi,
        cond_ge,     cond_lt,    cond_gt, cond_le
    } cond_t;

    // postbyte register bits
    localparam int pb_cc = 0;
    localparam int pb_a  = 1;
    localparam int pb_b  = 2;
    localparam int pb_dp = 3;
    localparam int pb_x  = 4;
    localparam int pb_y  = 5;
    localparam int pb_u  = 6;
    localparam int pb_pc = 7;

    // registers that take two bytes on the stack
    localparam logic [7:0] pb_wide = 8'hf0;

endpackage

`default_nettype wire

/* hw/stack_seq.sv */
// Push and pull sequencer
`timescale 1ns/1ns
`default_nettype none

module stack_seq (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  logic                  mem_busy,
    input  logic            [7:0] postdata,
    input  ctrl_pkg::uc_word_t    uc,
    output ctrl_pkg::stack_ctrl_t stk
);

    logic       active;
    logic [7:0] mask;
    logic       push;
    logic       second;
    logic [7:0] sel;
    logic       wide;
    logic       last;

    assign active = cen & ~mem_busy;

    // push serves the highest pending bit first, pull the lowest
    always_comb begin
        sel = 8'd0;
        if (push) begin
            for (int i = 0; i < 8; i++) begin
                if (mask[i]) sel = 8'd1 << i;
            end
        end else begin
            for (int i = 7; i >= 0; i--) begin
                if (mask[i]) sel = 8'd1 << i;
            end
        end
    end

    assign wide = |(sel & isa_pkg::pb_wide);
    // 8-bit registers finish in one byte, 16-bit ones on the second
    assign last = ~wide | second;

    // postbyte is sampled in the operand cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            mask   <= 8'd0;
            push   <= 1'b0;
            second <= 1'b0;
        end else if (active) begin
            if (uc.opd && (uc.psh_go || uc.pul_go)) begin
                mask   <= postdata;
                push   <= uc.psh_go;
                second <= 1'b0;
            end else if (|mask) begin
                if (last) begin
                    mask   <= mask & ~sel;
                    second <= 1'b0;
                end else begin
                    second <= 1'b1;
                end
            end
        end
    end

    // push sends low byte first, pull takes high byte first
    assign stk = '{
        psh_sel: sel,
        hi_lon:  wide & (push ? second : ~second),
        wrq:     push & (|mask),
        pul_en:  ~push & (|mask),
        busy:    (|(mask & ~sel)) | (wide & ~second)
    };

endmodule

`default_nettype wire

/* hw/ucode_seq.sv */
// Instruction microcode sequencer
`timescale 1ns/1ns
`default_nettype none

module ucode_seq (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               mem_busy,
    input  logic         [7:0] op,
    input  logic               branch,
    input  logic               stk_busy,
    output ctrl_pkg::uc_word_t uc
);

    typedef enum logic [1:0] {
        st_fetch,
        st_opd,
        st_exec
    } state_t;

    state_t     state;
    logic [1:0] left;
    logic       active;
    logic       is_ld8;
    logic       is_ld16;
    logic       is_sbr;
    logic       is_lbr;
    logic       is_jmp;
    logic       is_psh;
    logic       is_pul;
    logic       wide_opd;
    logic [1:0] nbytes;
    logic       exec_done;

    assign active = cen & ~mem_busy;

    // opcode classes, anything else falls through as nop
    assign is_ld8  = op == isa_pkg::op_lda || op == isa_pkg::op_ldb;
    assign is_ld16 = op inside {isa_pkg::op_ldd, isa_pkg::op_ldx, isa_pkg::op_ldy,
                                isa_pkg::op_ldu, isa_pkg::op_lds};
    assign is_sbr  = op[7:4] == isa_pkg::grp_sbr;
    assign is_lbr  = op[7:4] == isa_pkg::grp_lbr;
    assign is_jmp  = op == isa_pkg::op_jmp;
    assign is_psh  = op == isa_pkg::op_pshs;
    assign is_pul  = op == isa_pkg::op_puls;

    assign wide_opd = is_ld16 | is_lbr | is_jmp;
    assign nbytes   = wide_opd ? 2'd2 :
                      (is_ld8 | is_sbr | is_psh | is_pul) ? 2'd1 : 2'd0;

    // stack ops stay in execute until the last byte goes out
    assign exec_done = (is_psh | is_pul) ? ~stk_busy : 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_fetch;
            left  <= 2'd0;
        end else if (active) begin
            case (state)
                st_fetch: begin
                    if (nbytes == 2'd0) begin
                        state <= st_exec;
                    end else begin
                        state <= st_opd;
                        left  <= nbytes - 2'd1;
                    end
                end
                st_opd: begin
                    if (left == 2'd0) state <= st_exec;
                    else left <= left - 2'd1;
                end
                st_exec: begin
                    if (exec_done) state <= st_fetch;
                end
                default: state <= st_fetch;
            endcase
        end
    end

    always_comb begin
        uc = '0;
        case (state)
            st_fetch: uc.pc_step = 1'b1;
            st_opd: begin
                uc.pc_step = 1'b1;
                uc.opd     = 1'b1;
                uc.mem16   = wide_opd;
                uc.psh_go  = is_psh;
                uc.pul_go  = is_pul;
            end
            st_exec: begin
                uc.set_pc_branch8  = is_sbr & branch;
                uc.set_pc_branch16 = is_lbr & branch;
                uc.set_pc_jmp      = is_jmp;
                uc.up_ld8          = is_ld8;
                uc.up_ld16         = is_ld16;
                uc.ni              = exec_done;
            end
            default: uc = '0;
        endcase
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_ctrl_tb \
    -f filelist.f --Mdir obj_dir -o sim_cpu_ctrl
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_cpu_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All tests passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
